/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_hsid_main \
		-f verilog.f --Mdir obj_dir -o sim_hsid
	./obj_dir/sim_hsid

clean:
	rm -rf obj_dir

/* hsid_checker.sv */
`timescale 1ns/10ps

module hsid_checker (
  input logic clk,
  input logic reset,
  input logic start,
  input logic idle,
  input logic ready,
  input logic done
);

  // Never accepting words while waiting for start
  idle_ready_excl: assert property (@(posedge clk) disable iff (reset) !(idle && ready))
    else $error("idle and ready high together");

  done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done held longer than one cycle");

  // A run begins only from a start seen in idle
  start_in_idle: assert property (@(posedge clk) disable iff (reset)
    $fell(idle) |-> $past(start && idle))
    else $error("left idle without an accepted start");

  ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> !ready)
    else $error("ready high on the first cycle after reset");

endmodule

/* hsid_fifo.sv */
`timescale 1ns/10ps

module hsid_fifo #(
  parameter int DEPTH = hsid_pkg::BUFFER_LENGTH // Entries, in words
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     clear,                 // Drops all contents
  input  logic                     loop_en,               // Read word goes back to the tail
  input  logic                     wr_en,
  input  logic                     rd_en,
  input  hsid_pkg::word_t          data_in,
  input  hsid_pkg::element_count_t almost_full_threshold, // Fill level for almost_full
  output hsid_pkg::word_t          data_out,              // Registered read word
  output logic                     full,
  output logic                     almost_full,
  output logic                     empty
);

  hsid_pkg::word_t          mem [DEPTH];          // Circular storage
  logic [$clog2(DEPTH)-1:0] wr_ptr;               // Tail
  logic [$clog2(DEPTH)-1:0] rd_ptr;               // Head
  hsid_pkg::element_count_t count;                // Fill level
  logic                     do_read;
  logic                     do_loop;
  logic                     do_write;
  hsid_pkg::word_t          wr_word;

  assign do_read  = rd_en && !empty;
  assign do_loop  = loop_en && do_read;           // Recirculate, level unchanged
  assign do_write = do_loop || (wr_en && !full);
  assign wr_word  = do_loop ? mem[rd_ptr] : data_in;

  assign full        = count == hsid_pkg::element_count_t'(DEPTH);
  assign empty       = count == '0;
  assign almost_full = count >= almost_full_threshold;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1; // Wrap at end
      if (do_read) rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (do_write && !do_read) count <= count + 1'b1;
      else if (do_read && !do_write) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr] <= wr_word;
    if (do_read) data_out <= mem[rd_ptr];        // Valid the cycle after the read
  end

endmodule

/* hsid_main.sv */
`timescale 1ns/10ps

module hsid_main (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    clear,              // Empties FIFOs, zeroes extremes
  input  logic                    hsi_vctr_in_valid,
  input  hsid_pkg::word_t         hsi_vctr_in,        // Two samples per word
  input  hsid_pkg::bands_t        hsi_bands_in,       // Sampled at start
  input  hsid_pkg::lib_ref_t      library_size_in,    // Sampled at start
  output logic                    ready,
  output logic                    idle,
  output logic                    done,
  output hsid_pkg::mse_extremes_t mse_extremes
);

  logic                  measure_wr_en;
  logic                  ref_wr_en;
  logic                  both_rd_en;
  logic                  measure_almost_full;
  logic                  ref_empty;
  logic                  ref_full;
  logic                  element_valid;
  logic                  element_start;
  logic                  element_last;
  hsid_pkg::lib_ref_t    vctr_ref;
  hsid_pkg::word_t       measure_word;               // Looping measured vector
  hsid_pkg::word_t       ref_word;
  logic                  mse_valid;
  hsid_pkg::mse_result_t mse;
  logic                  compare_valid;

  hsid_main_fsm #(
    .HSI_BANDS_LIMIT(hsid_pkg::HSI_BANDS_MAX)
  ) fsm (
    .clk(clk), .reset(reset), .start(start),
    .hsi_bands(hsi_bands_in), .library_size(library_size_in),
    .hsi_vctr_in_valid(hsi_vctr_in_valid), .measure_almost_full(measure_almost_full),
    .ref_empty(ref_empty), .ref_full(ref_full), .compare_valid(compare_valid),
    .state(), .measure_wr_en(measure_wr_en), .ref_wr_en(ref_wr_en),
    .both_rd_en(both_rd_en), .element_valid(element_valid),
    .element_start(element_start), .element_last(element_last), .vctr_ref(vctr_ref),
    .ready(ready), .idle(idle), .done(done)
  );

  // Measured vector recirculates and is dropped at the end of each run
  hsid_fifo #(.DEPTH(hsid_pkg::ELEMENTS_MAX)) fifo_measure (
    .clk(clk), .reset(reset), .clear(clear || done), .loop_en(1'b1),
    .wr_en(measure_wr_en), .rd_en(both_rd_en), .data_in(hsi_vctr_in),
    .almost_full_threshold(hsid_pkg::element_count_t'(hsid_pkg::ELEMENTS_MAX)),
    .data_out(measure_word), .full(), .almost_full(measure_almost_full), .empty()
  );

  hsid_fifo #(.DEPTH(hsid_pkg::BUFFER_LENGTH)) fifo_ref (
    .clk(clk), .reset(reset), .clear(clear), .loop_en(1'b0),
    .wr_en(ref_wr_en), .rd_en(both_rd_en), .data_in(hsi_vctr_in),
    .almost_full_threshold(hsid_pkg::element_count_t'(hsid_pkg::BUFFER_LENGTH - 1)),
    .data_out(ref_word), .full(ref_full), .almost_full(), .empty(ref_empty)
  );

  hsid_mse mse_unit (
    .clk(clk), .reset(reset), .element_valid(element_valid),
    .element_start(element_start), .element_last(element_last),
    .hsi_bands(hsi_bands_in), .vctr_ref(vctr_ref),
    .element_a(measure_word), .element_b(ref_word),
    .mse_valid(mse_valid), .mse(mse)
  );

  hsid_mse_comp mse_comp (
    .clk(clk), .reset(reset), .clear(clear), .mse_valid(mse_valid), .mse(mse),
    .extremes(mse_extremes), .compare_valid(compare_valid)
  );

endmodule

/* hsid_main_fsm.sv */
`timescale 1ns/10ps

module hsid_main_fsm #(
  parameter int HSI_BANDS_LIMIT = hsid_pkg::HSI_BANDS_MAX // Band count ceiling
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  hsid_pkg::bands_t      hsi_bands,
  input  hsid_pkg::lib_ref_t    library_size,
  input  logic                  hsi_vctr_in_valid,
  input  logic                  measure_almost_full,
  input  logic                  ref_empty,
  input  logic                  ref_full,
  input  logic                  compare_valid,     // One per finished reference
  output hsid_pkg::hsid_state_t state,
  output logic                  measure_wr_en,
  output logic                  ref_wr_en,
  output logic                  both_rd_en,        // Common read of both FIFOs
  output logic                  element_valid,     // Aligned with FIFO data
  output logic                  element_start,
  output logic                  element_last,
  output hsid_pkg::lib_ref_t    vctr_ref,
  output logic                  ready,
  output logic                  idle,
  output logic                  done
);

  hsid_pkg::bands_t         bands_r;                   // Sampled at start
  hsid_pkg::lib_ref_t       lib_size_r;
  hsid_pkg::element_count_t element_threshold;         // Words per vector
  hsid_pkg::element_count_t elem_last_idx;
  hsid_pkg::element_count_t in_word_cnt;               // Word position on the input side
  hsid_pkg::lib_ref_t       in_vctr_cnt;               // References taken
  logic                     in_done;                   // Whole library taken
  hsid_pkg::element_count_t rd_word_cnt;               // Word position on the read side
  hsid_pkg::lib_ref_t       rd_vctr_cnt;               // References issued
  hsid_pkg::lib_ref_t       res_cnt;                   // Results received
  logic                     take;
  logic                     in_word_last;
  logic                     rd_word_last;

  assign element_threshold = hsid_pkg::element_count_t'(({1'b0, bands_r} + 9'd1) >> 1);
  assign elem_last_idx     = element_threshold - hsid_pkg::element_count_t'(1);

  assign idle  = state == hsid_pkg::IDLE;
  assign done  = state == hsid_pkg::FINISH;
  assign ready = (state == hsid_pkg::READ_MEASURE) ||
                 (state == hsid_pkg::COMPUTE_MSE && !ref_full && !in_done);
  assign take  = hsi_vctr_in_valid && ready;

  assign in_word_last  = in_word_cnt == elem_last_idx;
  assign rd_word_last  = rd_word_cnt == elem_last_idx;
  assign measure_wr_en = take && state == hsid_pkg::READ_MEASURE && !measure_almost_full;
  assign ref_wr_en     = take && state == hsid_pkg::COMPUTE_MSE;
  // Last word of a vector waits until the previous division has reported
  assign both_rd_en    = state == hsid_pkg::COMPUTE_MSE && !ref_empty &&
                         (!rd_word_last || res_cnt == rd_vctr_cnt);

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= hsid_pkg::IDLE;
      in_word_cnt   <= '0;
      in_vctr_cnt   <= '0;
      in_done       <= 1'b0;
      rd_word_cnt   <= '0;
      rd_vctr_cnt   <= '0;
      res_cnt       <= '0;
      element_valid <= 1'b0;
      element_start <= 1'b0;
      element_last  <= 1'b0;
    end else begin
      element_valid <= both_rd_en;
      element_start <= both_rd_en && rd_word_cnt == '0;
      element_last  <= both_rd_en && rd_word_last;
      if (compare_valid) res_cnt <= res_cnt + 1'b1;
      case (state)
        hsid_pkg::IDLE: if (start) begin
          in_word_cnt <= '0;
          in_vctr_cnt <= '0;
          in_done     <= 1'b0;
          rd_word_cnt <= '0;
          rd_vctr_cnt <= '0;
          res_cnt     <= '0;
          state       <= hsid_pkg::READ_MEASURE;
        end
        hsid_pkg::READ_MEASURE: if (take) begin
          in_word_cnt <= in_word_last ? '0 : in_word_cnt + 1'b1;
          if (in_word_last) state <= hsid_pkg::COMPUTE_MSE; // Measured pixel complete
        end
        hsid_pkg::COMPUTE_MSE: begin
          if (take) begin
            in_word_cnt <= in_word_last ? '0 : in_word_cnt + 1'b1;
            if (in_word_last) in_vctr_cnt <= in_vctr_cnt + 1'b1;
            if (in_word_last && in_vctr_cnt == lib_size_r - 1'b1) in_done <= 1'b1;
          end
          if (both_rd_en) begin
            rd_word_cnt <= rd_word_last ? '0 : rd_word_cnt + 1'b1;
            if (rd_word_last) rd_vctr_cnt <= rd_vctr_cnt + 1'b1;
            if (rd_word_last && rd_vctr_cnt == lib_size_r - 1'b1) begin
              state <= hsid_pkg::WAIT_RESULTS;            // Every reference word read
            end
          end
        end
        hsid_pkg::WAIT_RESULTS: if (res_cnt == lib_size_r) state <= hsid_pkg::FINISH;
        hsid_pkg::FINISH: state <= hsid_pkg::IDLE;
        default: state <= hsid_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (idle && start) begin
      bands_r    <= (int'(hsi_bands) > HSI_BANDS_LIMIT) ?
                    hsid_pkg::bands_t'(HSI_BANDS_LIMIT) : hsi_bands;
      lib_size_r <= library_size;
    end
    if (both_rd_en) vctr_ref <= rd_vctr_cnt;          // Travels with element_valid
  end

endmodule

/* hsid_mse.sv */
`timescale 1ns/10ps

module hsid_mse (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  element_valid,
  input  logic                  element_start, // First word of a vector
  input  logic                  element_last,  // Last word of a vector
  input  hsid_pkg::bands_t      hsi_bands,     // Held for the whole run
  input  hsid_pkg::lib_ref_t    vctr_ref,
  input  hsid_pkg::word_t       element_a,     // Measured word
  input  hsid_pkg::word_t       element_b,     // Reference word
  output logic                  mse_valid,
  output hsid_pkg::mse_result_t mse
);

  hsid_pkg::sample_t a_lo, a_hi, b_lo, b_hi;
  hsid_pkg::sample_t diff_lo, diff_hi;
  hsid_pkg::square_t sq_lo, sq_hi;
  hsid_pkg::acc_t    sum;                        // Partial sum of the current vector
  hsid_pkg::acc_t    sum_next;
  logic              mask_hi;
  logic              div_busy;
  logic              div_last;
  logic [$clog2(hsid_pkg::ACC_WIDTH)-1:0] div_cnt; // Quotient bit counter
  hsid_pkg::acc_t    div_quo, div_quo_next;      // Dividend in, quotient out
  hsid_pkg::bands_t  div_rem, div_rem_next;      // Partial remainder
  hsid_pkg::bands_t  div_divisor;
  hsid_pkg::lib_ref_t div_ref;
  logic [$bits(hsid_pkg::bands_t):0] rem_shift, rem_diff;

  assign a_lo = element_a[hsid_pkg::DATA_WIDTH-1:0];
  assign a_hi = element_a[hsid_pkg::WORD_WIDTH-1:hsid_pkg::DATA_WIDTH];
  assign b_lo = element_b[hsid_pkg::DATA_WIDTH-1:0];
  assign b_hi = element_b[hsid_pkg::WORD_WIDTH-1:hsid_pkg::DATA_WIDTH];
  assign diff_lo = (a_lo > b_lo) ? a_lo - b_lo : b_lo - a_lo; // Unsigned distance
  assign diff_hi = (a_hi > b_hi) ? a_hi - b_hi : b_hi - a_hi;
  assign sq_lo   = diff_lo * diff_lo;
  assign sq_hi   = diff_hi * diff_hi;
  assign mask_hi = element_last && hsi_bands[0];  // Odd count has no upper band
  assign sum_next = (element_start ? '0 : sum) + hsid_pkg::acc_t'(sq_lo) +
                    (mask_hi ? '0 : hsid_pkg::acc_t'(sq_hi));

  // Restoring division step, one quotient bit per cycle
  assign rem_shift = {div_rem, div_quo[hsid_pkg::ACC_WIDTH-1]};
  assign rem_diff  = rem_shift - {1'b0, div_divisor};
  assign div_last  = div_busy && int'(div_cnt) == hsid_pkg::ACC_WIDTH - 1;

  always_comb begin
    div_quo_next = {div_quo[hsid_pkg::ACC_WIDTH-2:0], rem_shift >= {1'b0, div_divisor}};
    div_rem_next = (rem_shift >= {1'b0, div_divisor}) ?
                   hsid_pkg::bands_t'(rem_diff) : hsid_pkg::bands_t'(rem_shift);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      div_busy  <= 1'b0;
      div_cnt   <= '0;
      mse_valid <= 1'b0;
    end else begin
      mse_valid <= div_last;                     // 48 cycles after the load
      if (element_valid && element_last) begin
        div_busy <= 1'b1;
        div_cnt  <= '0;
      end else if (div_busy) begin
        div_cnt  <= div_cnt + 1'b1;
        if (div_last) div_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (element_valid) sum <= sum_next;
    if (element_valid && element_last) begin   // Hand off, next vector restarts the sum
      div_quo     <= sum_next;
      div_rem     <= '0;
      div_divisor <= hsi_bands;
      div_ref     <= vctr_ref;
    end else if (div_busy) begin
      div_quo <= div_quo_next;
      div_rem <= div_rem_next;
    end
    if (div_last) begin
      mse.value    <= (|div_quo_next[hsid_pkg::ACC_WIDTH-1:hsid_pkg::WORD_WIDTH]) ?
                      '1 : div_quo_next[hsid_pkg::WORD_WIDTH-1:0]; // Saturate to 32 bits
      mse.vctr_ref <= div_ref;
    end
  end

endmodule

/* hsid_mse_comp.sv */
`timescale 1ns/10ps

module hsid_mse_comp (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clear,         // Forget all earlier results
  input  logic                    mse_valid,
  input  hsid_pkg::mse_result_t   mse,
  output hsid_pkg::mse_extremes_t extremes,
  output logic                    compare_valid  // Extremes updated
);

  logic first;                                   // Next result seeds both ends

  always_ff @(posedge clk) begin
    if (reset) begin
      extremes      <= '0;
      first         <= 1'b1;
      compare_valid <= 1'b0;
    end else begin
      compare_valid <= mse_valid;                // Still reported across a clear
      if (clear) begin
        extremes <= '0;
        first    <= 1'b1;
      end else if (mse_valid) begin
        if (first) begin
          extremes.min <= mse;
          extremes.max <= mse;
          first        <= 1'b0;
        end else begin
          // Strict compares, earlier index wins a tie
          if (mse.value < extremes.min.value) extremes.min <= mse;
          if (mse.value > extremes.max.value) extremes.max <= mse;
        end
      end
    end
  end

endmodule

/* hsid_pkg.sv */
package hsid_pkg;

  localparam int WORD_WIDTH       = 32;   // Input word, two samples
  localparam int DATA_WIDTH       = 16;   // One band sample
  localparam int ACC_WIDTH        = 48;   // Error sum over all bands
  localparam int HSI_BANDS_MAX    = 255;  // Largest band count
  localparam int ELEMENTS_MAX     = 128;  // Words in the longest vector
  localparam int BUFFER_LENGTH    = 4;    // Reference FIFO depth
  localparam int LIBRARY_SIZE_MAX = 4095; // Largest library

  typedef logic [WORD_WIDTH-1:0]   word_t;   // Packed sample pair
  typedef logic [DATA_WIDTH-1:0]   sample_t; // Unsigned band sample
  typedef logic [2*DATA_WIDTH-1:0] square_t; // Squared difference
  typedef logic [ACC_WIDTH-1:0]    acc_t;    // Running error sum

  typedef logic [$clog2(HSI_BANDS_MAX+1)-1:0]    bands_t;         // Band count
  typedef logic [$clog2(ELEMENTS_MAX+1)-1:0]     element_count_t; // Words within a vector
  typedef logic [$clog2(LIBRARY_SIZE_MAX+1)-1:0] lib_ref_t;       // Library index or size

  // Top-level control sequence
  typedef enum logic [2:0] {
    IDLE,         // Waiting for start
    READ_MEASURE, // Measured pixel into its FIFO
    COMPUTE_MSE,  // Library streaming through
    WAIT_RESULTS, // Last divisions draining
    FINISH        // One-cycle done
  } hsid_state_t;

  // One error value tagged with its library index
  typedef struct packed {
    word_t    value;    // Mean squared error
    lib_ref_t vctr_ref; // Library index
  } mse_result_t;

  // Best and worst match seen so far
  typedef struct packed {
    mse_result_t min; // Smallest error
    mse_result_t max; // Largest error
  } mse_extremes_t;

endpackage

/* tb_hsid_main.sv */
`timescale 1ns/10ps

module tb_hsid_main;

  localparam int TIMEOUT = 20000;               // Cycles allowed per wait

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    start;
  logic                    clear;
  logic                    hsi_vctr_in_valid;
  hsid_pkg::word_t         hsi_vctr_in;
  hsid_pkg::bands_t        hsi_bands_in;
  hsid_pkg::lib_ref_t      library_size_in;
  logic                    ready;
  logic                    idle;
  logic                    done;
  hsid_pkg::mse_extremes_t mse_extremes;

  hsid_pkg::sample_t       meas_s [256];        // Measured pixel with a spare slot for odd counts
  hsid_pkg::sample_t       lib_s [16][256];     // Reference library
  hsid_pkg::mse_extremes_t model;               // Expected extremes
  logic                    model_first;         // Next model result seeds both ends
  logic [31:0]             lcg_state = 32'd49;
  int                      done_count;          // done pulses in this run
  int                      stall_count;         // Cycles a word waited on ready

  hsid_main i_hsid_main (.*);

  bind hsid_main hsid_checker u_checker (
    .clk(clk), .reset(reset), .start(start), .idle(idle), .ready(ready), .done(done)
  );

  always #10 clk = ~clk;                        // 20 ns period

  always @(negedge clk) begin                   // Mid-cycle when outputs have settled
    if (done) done_count++;
    if (hsi_vctr_in_valid && !ready && !idle) stall_count++;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic hsid_pkg::sample_t random_sample();
    logic [31:0] v;
    v = next_random();
    return v[31:16];                            // Upper bits spread better
  endfunction

  // Truncated mean of squared differences over the active bands
  function automatic hsid_pkg::word_t model_mse(int r, int bands);
    logic [47:0] sum;
    logic [47:0] mean;
    longint      d;
    sum = '0;
    for (int i = 0; i < bands; i++) begin
      d = longint'(meas_s[i]) - longint'(lib_s[r][i]);
      sum += 48'(d * d);
    end
    mean = sum / 48'(bands);
    return (mean > 48'hFFFF_FFFF) ? 32'hFFFF_FFFF : mean[31:0];
  endfunction

  task automatic model_add(hsid_pkg::word_t value, int r);
    hsid_pkg::mse_result_t res;
    res.value    = value;
    res.vctr_ref = hsid_pkg::lib_ref_t'(r);
    if (model_first) begin
      model.min   = res;
      model.max   = res;
      model_first = 1'b0;
    end else begin
      if (value < model.min.value) model.min = res;   // Strict so the first one wins ties
      if (value > model.max.value) model.max = res;
    end
  endtask

  task automatic compare_result(string name, hsid_pkg::mse_result_t exp,
                                hsid_pkg::mse_result_t act);
    if (act !== exp) begin
      $display("** Error %s: expected value %0d ref %0d, actual value %0d ref %0d",
               name, exp.value, exp.vctr_ref, act.value, act.vctr_ref);
      $display("Simulation FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic compare_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic timeout_check(string name, int n, string what);
    if (n > TIMEOUT) begin
      $display("Test %s timed out waiting for %s", name, what);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_word(string name, hsid_pkg::word_t w, logic gaps);
    int gap;
    int n;
    gap = gaps ? int'(next_random() % 32'd4) : 0;
    if (gap > 0) hsi_vctr_in_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    hsi_vctr_in_valid = 1'b1;
    hsi_vctr_in       = w;
    n = 0;
    @(negedge clk);
    while (ready !== 1'b1) begin                // Word held while back-pressured
      n++;
      timeout_check(name, n, "ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_done(string name);
    int n;
    n = 0;
    @(negedge clk);
    while (done !== 1'b1) begin
      n++;
      timeout_check(name, n, "done");
      @(negedge clk);
    end
    @(negedge clk);
    compare_flag({name, " done low after pulse"}, 1'b0, done);
    compare_flag({name, " idle after done"}, 1'b1, idle);
    compare_flag({name, " one done pulse"}, 1'b1, done_count == 1);
    @(posedge clk);
    #1;
  endtask

  task automatic run_library(string name, int bands, int lib_size, logic gaps);
    int words;
    words           = (bands + 1) / 2;
    done_count      = 0;
    stall_count     = 0;
    hsi_bands_in    = hsid_pkg::bands_t'(bands);  // Held until the next run
    library_size_in = hsid_pkg::lib_ref_t'(lib_size);
    start           = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    for (int w = 0; w < words; w++) send_word(name, {meas_s[2*w+1], meas_s[2*w]}, gaps);
    for (int r = 0; r < lib_size; r++) begin
      for (int w = 0; w < words; w++) begin
        send_word(name, {lib_s[r][2*w+1], lib_s[r][2*w]}, gaps);
      end
    end
    hsi_vctr_in_valid = 1'b0;
    wait_done(name);
    for (int r = 0; r < lib_size; r++) model_add(model_mse(r, bands), r);
    compare_result({name, " min"}, model.min, mse_extremes.min);
    compare_result({name, " max"}, model.max, mse_extremes.max);
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear       = 1'b0;
    model       = '0;
    model_first = 1'b1;
    compare_result("clear min", '0, mse_extremes.min);
    compare_result("clear max", '0, mse_extremes.max);
  endtask

  task automatic fill_measure();
    for (int i = 0; i < 256; i++) meas_s[i] = random_sample();
  endtask

  task automatic fill_library(int n);
    for (int r = 0; r < n; r++) begin
      for (int i = 0; i < 256; i++) lib_s[r][i] = random_sample();
    end
  endtask

  // Off by one LSB per band for a near-perfect match
  task automatic set_near(int r);
    for (int i = 0; i < 256; i++) lib_s[r][i] = meas_s[i] ^ 16'h0001;
  endtask

  // Farthest sample per band that nothing random can exceed
  task automatic set_far(int r);
    for (int i = 0; i < 256; i++) lib_s[r][i] = meas_s[i][15] ? 16'h0000 : 16'hFFFF;
  endtask

  task automatic copy_ref(int dst, int src);
    for (int i = 0; i < 256; i++) lib_s[dst][i] = lib_s[src][i];
  endtask

  task automatic test_reset();
    compare_flag("reset_state idle", 1'b1, idle);
    compare_flag("reset_state ready", 1'b0, ready);
    compare_flag("reset_state done", 1'b0, done);
    compare_result("reset_state min", '0, mse_extremes.min);
    compare_result("reset_state max", '0, mse_extremes.max);
  endtask

  task automatic test_single_match();
    fill_measure();
    for (int i = 0; i < 256; i++) lib_s[0][i] = meas_s[i];
    run_library("single_match", 255, 1, 1'b0);
    compare_result("single_match zero", '0, mse_extremes.min);
  endtask

  task automatic test_random_library();
    pulse_clear();
    fill_measure();
    fill_library(8);
    run_library("random_library", 255, 8, 1'b1);
  endtask

  task automatic test_ties_and_odd();
    pulse_clear();
    fill_measure();
    fill_library(6);
    set_near(1);
    set_far(2);
    copy_ref(3, 1);                             // Ties later in the library
    copy_ref(4, 2);
    run_library("even_ties", 16, 6, 1'b1);
    pulse_clear();
    fill_measure();
    fill_library(4);
    set_near(1);
    copy_ref(3, 1);
    run_library("odd_bands", 7, 4, 1'b1);       // Upper half of word 3 is noise
  endtask

  task automatic test_back_pressure();
    pulse_clear();
    fill_measure();
    fill_library(12);
    run_library("back_pressure", 20, 12, 1'b0);
    compare_flag("back_pressure stalled", 1'b1, stall_count > 0);
  endtask

  task automatic test_carry_and_clear();
    pulse_clear();
    fill_measure();
    fill_library(4);
    set_near(2);
    run_library("carry_first", 10, 4, 1'b1);
    fill_library(3);
    set_far(1);
    run_library("carry_over", 10, 3, 1'b1);     // Earlier min stays and max moves to ref 1
    pulse_clear();
    fill_measure();
    fill_library(3);
    run_library("after_clear", 10, 3, 1'b1);
  endtask

  initial begin
    reset             = 1'b1;
    start             = 1'b0;
    clear             = 1'b0;
    hsi_vctr_in_valid = 1'b0;
    hsi_vctr_in       = '0;
    hsi_bands_in      = '0;
    library_size_in   = '0;
    model             = '0;
    model_first       = 1'b1;
    done_count        = 0;
    stall_count       = 0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset();
    test_single_match();
    test_random_library();
    test_ties_and_odd();
    test_back_pressure();
    test_carry_and_clear();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* verilog.f */
hsid_pkg.sv
hsid_fifo.sv
hsid_main_fsm.sv
hsid_mse.sv
hsid_mse_comp.sv
hsid_main.sv
hsid_checker.sv
tb_hsid_main.sv
